// File: verilog/cpu_defines.svh
// Core-wide sizing, reset address and bubble word for the MIPS subset pipeline
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ----------------------------------------
// Datapath sizing
// ----------------------------------------
`define CPU_WIDTH      32            // One word, data and address
`define CPU_REG_COUNT  32            // General registers r0..r31
`define CPU_REG_BITS   5             // Register index width

// ----------------------------------------
// Program counter
// ----------------------------------------
`define CPU_PC_RESET   32'h0000_0000 // First fetch after reset
`define CPU_PC_STEP    32'd4         // One instruction per fetch

// ----------------------------------------
// Bubble
// ----------------------------------------
// All-zero word, SPECIAL with an unused function code, so it writes nothing
`define CPU_NOP        32'h0000_0000

`endif

// File: verilog/isaPkg.sv
// Instruction-set package: opcodes, function codes, instruction field layout and ALU operations
`include "cpu_defines.svh"

package isaPkg;

	typedef logic [`CPU_WIDTH-1:0]    word_t;
	typedef logic [`CPU_REG_BITS-1:0] regIndex_t;

	// Kept primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, // R-type, see funct
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	// Kept SPECIAL function codes, bits 5:0
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_t;

	// Low half seen as R-type fields or as the 16-bit immediate
	typedef struct packed {
		regIndex_t  rd;
		logic [4:0] shamt;
		funct_t     funct;
	} rTypeLow_t;

	typedef union packed {
		rTypeLow_t   rType;
		logic [15:0] immediate;
	} lowHalf_t;

	// Whole word; the jump target is bits 25:0 across rs, rt and low
	typedef struct packed {
		opcode_t   opcode;
		regIndex_t rs;
		regIndex_t rt;
		lowHalf_t  low;
	} instrFields_t;

	// UPPER is B shifted left 16, for LUI
	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_UPPER} aluOp_t;

endpackage

// File: verilog/pipePkg.sv
// Pipeline package: bundles passed between stages and the data port structs
package pipePkg;

	import isaPkg::*;

	// ----------------------------------------
	// Stage bundles
	// ----------------------------------------
	typedef struct packed {
		word_t instruction; // NOP when bubbled
		word_t pcPlus4;
	} fetchBundle_t;

	typedef struct packed {
		logic      regWrite;
		logic      memRead;       // LW
		logic      memWrite;      // SW
		logic      useImmediate;  // ALU B from immediate
		logic      isBranch;
		logic      branchOnEqual; // BEQ, else BNE
		logic      isJump;
		logic      isFlow;        // Branch or jump
		aluOp_t    aluOp;
		regIndex_t dest;
		regIndex_t rs;
		regIndex_t rt;
		word_t     operandA;      // Register file read of rs
		word_t     operandB;      // Register file read of rt
		word_t     immediate;     // Already extended
		word_t     pcPlus4;
		word_t     jumpTarget;
	} execBundle_t;

	typedef struct packed {
		logic      regWrite;
		regIndex_t dest;
		word_t     value;
	} writeBundle_t;

	// ----------------------------------------
	// Control and memory ports
	// ----------------------------------------
	typedef struct packed {
		logic  resolve; // Flow instruction sits in execute
		logic  taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		logic  read;
		logic  write;   // Store lands at the clock edge
		word_t address;
		word_t writeData;
	} dataRequest_t;

endpackage

// File: verilog/fetchUnit.sv
// Fetch stage: program counter, hold and redirect, bubble injection and the decode register
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetchUnit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  flowInDecode,
	input  pipePkg::redirect_t    redirect,
	input  isaPkg::word_t         instruction,
	output isaPkg::word_t         fetchAddress,
	output pipePkg::fetchBundle_t fetchBundle
);

	import isaPkg::*;

	word_t pc;
	word_t pcPlus4;
	word_t nextPc;
	logic  injectNop; // Bubble into decode

	assign fetchAddress = pc; // Instruction port is read in this cycle
	assign pcPlus4      = pc + `CPU_PC_STEP;
	assign injectNop    = flowInDecode | redirect.resolve;

	// ----------------------------------------
	// Next PC
	// ----------------------------------------
	// PC was held since the flow instruction reached decode,
	// so it already points at that instruction plus one step
	always_comb begin
		if (redirect.resolve) begin
			nextPc = redirect.taken ? redirect.target : pc; // Fall through resumes here
		end else if (flowInDecode) begin
			nextPc = pc;      // Hold behind branch or jump
		end else begin
			nextPc = pcPlus4; // Straight-line fetch
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `CPU_PC_RESET;
		end else begin
			pc <= nextPc;
		end
	end

	// ----------------------------------------
	// Fetch to decode register
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			fetchBundle.instruction <= `CPU_NOP;
			fetchBundle.pcPlus4     <= '0;
		end else begin
			fetchBundle.instruction <= injectNop ? `CPU_NOP : instruction;
			fetchBundle.pcPlus4     <= pcPlus4; // Branch base for this instruction
		end
	end

endmodule

// File: verilog/registerFile.sv
// Register file: 32 words, two read ports with write-through and r0 tied to zero
`timescale 1ns/100ps
`include "cpu_defines.svh"

module registerFile (
	input  logic                  clock,
	input  logic                  reset,
	input  isaPkg::regIndex_t     readIndexA,
	input  isaPkg::regIndex_t     readIndexB,
	output isaPkg::word_t         readDataA,
	output isaPkg::word_t         readDataB,
	input  pipePkg::writeBundle_t writeBundle
);

	import isaPkg::*;

	word_t regs [`CPU_REG_COUNT];
	logic  writeEnable;

	assign writeEnable = writeBundle.regWrite && (writeBundle.dest != '0); // r0 never written

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeBundle.dest] <= writeBundle.value;
		end
	end

	// Same-cycle write returns the new value
	assign readDataA = (readIndexA == '0) ? '0 :
		(writeEnable && writeBundle.dest == readIndexA) ? writeBundle.value : regs[readIndexA];
	assign readDataB = (readIndexB == '0) ? '0 :
		(writeEnable && writeBundle.dest == readIndexB) ? writeBundle.value : regs[readIndexB];

endmodule

// File: verilog/decodeUnit.sv
// Decode stage: field split, control decode, immediate extension and the execute register
`timescale 1ns/100ps
`include "cpu_defines.svh"

module decodeUnit (
	input  logic                  clock,
	input  logic                  reset,
	input  pipePkg::fetchBundle_t fetchBundle,
	input  pipePkg::writeBundle_t writeBundle,
	output logic                  flowInDecode,
	output pipePkg::execBundle_t  execBundle
);

	import isaPkg::*;
	import pipePkg::*;

	instrFields_t fields;
	execBundle_t  decoded;   // Next execute content
	word_t        signExt;
	word_t        zeroExt;   // ORI only
	word_t        readDataA;
	word_t        readDataB;

	assign fields  = instrFields_t'(fetchBundle.instruction);
	assign signExt = {{(`CPU_WIDTH-16){fields.low.immediate[15]}}, fields.low.immediate};
	assign zeroExt = {{(`CPU_WIDTH-16){1'b0}}, fields.low.immediate};

	// Write port comes straight from writeback
	registerFile regFile (
		.clock      (clock),
		.reset      (reset),
		.readIndexA (fields.rs),
		.readIndexB (fields.rt),
		.readDataA  (readDataA),
		.readDataB  (readDataB),
		.writeBundle(writeBundle)
	);

	// ----------------------------------------
	// Control decode
	// ----------------------------------------
	always_comb begin
		decoded            = '0; // Unknown opcodes do nothing
		decoded.aluOp      = ALU_ADD;
		decoded.dest       = (fields.opcode == OP_SPECIAL) ? fields.low.rType.rd : fields.rt;
		decoded.rs         = fields.rs;
		decoded.rt         = fields.rt;
		decoded.operandA   = readDataA;
		decoded.operandB   = readDataB;
		decoded.immediate  = signExt;
		decoded.pcPlus4    = fetchBundle.pcPlus4;
		// Region of PC+4, word index from the instruction
		decoded.jumpTarget = {fetchBundle.pcPlus4[`CPU_WIDTH-1 -: 4],
			fetchBundle.instruction[25:0], 2'b00};

		case (fields.opcode)
			OP_SPECIAL: begin
				decoded.regWrite = 1'b1;
				case (fields.low.rType.funct)
					FN_ADDU: decoded.aluOp = ALU_ADD;
					FN_SUBU: decoded.aluOp = ALU_SUB;
					FN_AND:  decoded.aluOp = ALU_AND;
					FN_OR:   decoded.aluOp = ALU_OR;
					FN_SLT:  decoded.aluOp = ALU_SLT;
					default: decoded.regWrite = 1'b0; // NOP lands here
				endcase
			end
			OP_ADDIU: begin
				decoded.regWrite     = 1'b1;
				decoded.useImmediate = 1'b1;
			end
			OP_ORI: begin
				decoded.regWrite     = 1'b1;
				decoded.useImmediate = 1'b1;
				decoded.aluOp        = ALU_OR;
				decoded.immediate    = zeroExt; // Logical immediate
			end
			OP_LUI: begin
				decoded.regWrite     = 1'b1;
				decoded.useImmediate = 1'b1;
				decoded.aluOp        = ALU_UPPER;
			end
			OP_LW: begin
				decoded.regWrite     = 1'b1;
				decoded.memRead      = 1'b1;
				decoded.useImmediate = 1'b1; // Base plus offset
			end
			OP_SW: begin
				decoded.memWrite     = 1'b1;
				decoded.useImmediate = 1'b1;
			end
			OP_BEQ: begin
				decoded.isBranch      = 1'b1;
				decoded.branchOnEqual = 1'b1;
			end
			OP_BNE:  decoded.isBranch = 1'b1;
			OP_J:    decoded.isJump   = 1'b1;
			default: decoded.regWrite = 1'b0;
		endcase

		decoded.isFlow = decoded.isBranch | decoded.isJump;
	end

	assign flowInDecode = decoded.isFlow; // Holds the PC in fetch

	// Decode to execute register
	always_ff @(posedge clock) begin
		if (reset) begin
			execBundle <= '0;
		end else begin
			execBundle <= decoded;
		end
	end

endmodule

// File: verilog/executeUnit.sv
// Execute and memory stage: forwarding, ALU, flow resolution, data port and writeback register
`timescale 1ns/100ps
`include "cpu_defines.svh"

module executeUnit (
	input  logic                  clock,
	input  logic                  reset,
	input  pipePkg::execBundle_t  execBundle,
	input  isaPkg::word_t         readData,
	output pipePkg::writeBundle_t writeBundle,
	output pipePkg::redirect_t    redirect,
	output pipePkg::dataRequest_t dataRequest
);

	import isaPkg::*;

	logic  forwardA;
	logic  forwardB;
	logic  operandsEqual;
	word_t operandA;     // rs after forwarding
	word_t operandB;     // rt after forwarding
	word_t aluB;
	word_t aluResult;
	word_t branchTarget;

	// ----------------------------------------
	// Forwarding from writeback
	// ----------------------------------------
	// Older producer two apart is covered by register file write-through
	assign forwardA = writeBundle.regWrite && (writeBundle.dest != '0)
		&& (writeBundle.dest == execBundle.rs);
	assign forwardB = writeBundle.regWrite && (writeBundle.dest != '0)
		&& (writeBundle.dest == execBundle.rt);

	assign operandA = forwardA ? writeBundle.value : execBundle.operandA;
	assign operandB = forwardB ? writeBundle.value : execBundle.operandB;
	assign aluB     = execBundle.useImmediate ? execBundle.immediate : operandB;

	// ----------------------------------------
	// ALU
	// ----------------------------------------
	always_comb begin
		case (execBundle.aluOp)
			ALU_ADD:   aluResult = operandA + aluB; // Also load and store address
			ALU_SUB:   aluResult = operandA - aluB;
			ALU_AND:   aluResult = operandA & aluB;
			ALU_OR:    aluResult = operandA | aluB;
			ALU_SLT:   aluResult = {{(`CPU_WIDTH-1){1'b0}}, $signed(operandA) < $signed(aluB)};
			ALU_UPPER: aluResult = aluB << 16; // LUI, A unused
			default:   aluResult = '0;
		endcase
	end

	// ----------------------------------------
	// Branch and jump resolution
	// ----------------------------------------
	assign operandsEqual = (operandA == operandB);
	assign branchTarget  = execBundle.pcPlus4 + (execBundle.immediate << 2);

	assign redirect.resolve = execBundle.isFlow;
	assign redirect.taken   = execBundle.isJump
		| (execBundle.isBranch & (operandsEqual == execBundle.branchOnEqual));
	assign redirect.target  = execBundle.isJump ? execBundle.jumpTarget : branchTarget;

	// Data port, answered in the same cycle
	assign dataRequest.read      = execBundle.memRead;
	assign dataRequest.write     = execBundle.memWrite;
	assign dataRequest.address   = aluResult;
	assign dataRequest.writeData = operandB;          // Forwarded rt

	// Execute to writeback register
	always_ff @(posedge clock) begin
		if (reset) begin
			writeBundle <= '0;
		end else begin
			writeBundle.regWrite <= execBundle.regWrite;
			writeBundle.dest     <= execBundle.dest;
			writeBundle.value    <= execBundle.memRead ? readData : aluResult; // Load or ALU
		end
	end

endmodule

// File: verilog/cpuCore.sv
// Core top level: fetch, decode with register file, and execute joined to the memory ports
`timescale 1ns/100ps

module cpuCore (
	input  logic                  clock,
	input  logic                  reset,
	output isaPkg::word_t         fetchAddress,
	input  isaPkg::word_t         instruction,
	output pipePkg::dataRequest_t dataRequest,
	input  isaPkg::word_t         readData
);

	import pipePkg::*;

	logic         flowInDecode; // Decode to fetch hold
	redirect_t    redirect;     // Execute to fetch
	fetchBundle_t fetchBundle;
	execBundle_t  execBundle;
	writeBundle_t writeBundle;  // To register file and forwarding

	fetchUnit fetchStage (
		.clock       (clock),
		.reset       (reset),
		.flowInDecode(flowInDecode),
		.redirect    (redirect),
		.instruction (instruction),
		.fetchAddress(fetchAddress),
		.fetchBundle (fetchBundle)
	);

	decodeUnit decodeStage (
		.clock       (clock),
		.reset       (reset),
		.fetchBundle (fetchBundle),
		.writeBundle (writeBundle),
		.flowInDecode(flowInDecode),
		.execBundle  (execBundle)
	);

	executeUnit executeStage (
		.clock      (clock),
		.reset      (reset),
		.execBundle (execBundle),
		.readData   (readData),
		.writeBundle(writeBundle),
		.redirect   (redirect),
		.dataRequest(dataRequest)
	);

endmodule

// File: bench/test_programs.svh
// Test programs: instruction images, data presets and expected store lists for each test
`ifndef TEST_PROGRAMS_SVH
`define TEST_PROGRAMS_SVH

// R-type word, shift amount unused
function automatic word_t encodeR(funct_t fn, int rd, int rs, int rt);
	return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

// I-type word in assembler order: rt, rs, immediate
function automatic word_t encodeI(opcode_t op, int rt, int rs, int imm);
	return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

task automatic emit(word_t instr);
	imem[progLen] = instr;
	progLen++;
endtask

task automatic expectStore(word_t address, word_t value);
	expAddr.push_back(address);
	expData.push_back(value);
endtask

// r1 = a and r2 = b on entry, r3..r7 stored from 0x80 up
task automatic aluBlock(word_t a, word_t b);
	word_t sum;
	word_t diff;
	word_t both;
	sum  = a + b;
	diff = sum - a;
	both = diff & sum;
	emit(encodeR(FN_ADDU, 3, 1, 2)); // r2 one back, r1 two back
	emit(encodeR(FN_SUBU, 4, 3, 1));
	emit(encodeR(FN_AND, 5, 4, 3));  // r4 one back, r3 two back
	emit(encodeR(FN_OR, 6, 5, 2));
	emit(encodeR(FN_SLT, 7, 1, 2));  // Signed compare
	for (int r = 3; r <= 7; r++) begin
		emit(encodeI(OP_SW, r, 0, 'h80 + 4 * (r - 3)));
	end
	expectStore(32'h80, sum);
	expectStore(32'h84, diff);
	expectStore(32'h88, both);
	expectStore(32'h8c, both | b);
	expectStore(32'h90, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
endtask

task automatic loadAluChain();
	emit(encodeI(OP_ADDIU, 1, 0, -9));
	emit(encodeI(OP_ADDIU, 2, 0, 3));
	aluBlock(32'hffff_fff7, 32'd3);
endtask

task automatic loadImmediates();
	emit(encodeI(OP_ADDIU, 1, 0, -5));
	emit(encodeI(OP_ORI, 2, 0, 'h8001));
	emit(encodeI(OP_LUI, 3, 0, 'habcd));
	emit(encodeI(OP_ORI, 4, 3, 'h1234)); // Lower half joins LUI result
	for (int r = 1; r <= 4; r++) begin
		emit(encodeI(OP_SW, r, 0, 'h60 + 4 * r));
	end
	expectStore(32'h64, 32'hffff_fffb); // Sign-extended
	expectStore(32'h68, 32'h0000_8001); // Zero-extended
	expectStore(32'h6c, 32'habcd_0000);
	expectStore(32'h70, 32'habcd_1234);
endtask

task automatic loadLoadUse();
	emit(encodeI(OP_ADDIU, 3, 0, 'h11));
	emit(encodeI(OP_LW, 1, 0, 'h20));
	emit(encodeR(FN_ADDU, 2, 1, 3)); // Consumes the load at once
	emit(encodeI(OP_SW, 2, 0, 'h24));
	expectStore(32'h24, fillWord(8) + 32'h11);
endtask

// Words 3..5 and 9..10 sit in skipped or bubbled slots
task automatic loadFlow();
	emit(encodeI(OP_ADDIU, 1, 0, 1));
	emit(encodeI(OP_ADDIU, 2, 0, 1));
	emit(encodeI(OP_BEQ, 2, 1, 3));   // Taken, lands on word 6
	emit(encodeI(OP_SW, 1, 0, 'h40));
	emit(encodeI(OP_SW, 1, 0, 'h44));
	emit(encodeI(OP_SW, 1, 0, 'h48));
	emit(encodeI(OP_BNE, 2, 1, 3));   // Not taken
	emit(encodeI(OP_SW, 2, 0, 'h50)); // Kept marker
	emit({OP_J, 26'd11});
	emit(encodeI(OP_SW, 1, 0, 'h54));
	emit(encodeI(OP_SW, 1, 0, 'h58));
	emit(encodeI(OP_ADDIU, 3, 0, 'h77));
	emit(encodeI(OP_SW, 3, 0, 'h5c));
	expectStore(32'h50, 32'd1);
	expectStore(32'h5c, 32'h77);
endtask

task automatic loadRandom();
	word_t a;
	word_t b;
	a = $random(seed);
	b = $random(seed);
	dmem[16] <= a; // Overrides the fill pattern
	dmem[17] <= b;
	emit(encodeI(OP_LW, 1, 0, 'h40));
	emit(encodeI(OP_LW, 2, 0, 'h44));
	aluBlock(a, b);
endtask

`endif

// File: bench/cpuTb.sv
// Testbench for the pipelined MIPS subset core with memory models and store checks
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpuTb;

	import isaPkg::*;
	import pipePkg::*;

	localparam int PERIOD          = 100;
	localparam int MEM_WORDS       = 64;
	localparam int PROGRAM_WORDS   = 50; // All programs together, rounded up
	localparam int TEST_COUNT      = 5;
	localparam int WATCHDOG_CYCLES = PROGRAM_WORDS * 3 + TEST_COUNT * 20;

	logic         clock;
	logic         reset;
	word_t        fetchAddress;
	word_t        instruction;
	dataRequest_t dataRequest;
	word_t        readData;

	word_t  imem [MEM_WORDS];
	word_t  dmem [MEM_WORDS];
	word_t  expAddr [$]; // Pending stores, oldest first
	word_t  expData [$];
	int     progLen;
	int     readsSeen;   // Read strobes in the current test
	int     errorCount;
	int     testsPassed;
	int     testsFailed;
	bit     resetApplied; // Reset has reached the core through a clock edge
	integer seed = 32'h1b20;

	cpuCore i_dut (
		.clock       (clock),
		.reset       (reset),
		.fetchAddress(fetchAddress),
		.instruction (instruction),
		.dataRequest (dataRequest),
		.readData    (readData)
	);

	// ----------------------------------------
	// Clock and memory models
	// ----------------------------------------
	always #(PERIOD / 2) clock = ~clock;

	assign instruction = imem[fetchAddress[7:2]];        // Same-cycle instruction port
	assign readData    = dmem[dataRequest.address[7:2]];

	always @(posedge clock) begin
		if (dataRequest.write) begin
			dmem[dataRequest.address[7:2]] <= dataRequest.writeData;
		end
	end

	always @(posedge clock) begin
		resetApplied <= reset;
	end

	function automatic word_t fillWord(int index);
		return 32'hd0d0_0000 + 32'(index * 4); // Byte address in the low bits
	endfunction

	task automatic clearMemories();
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = `CPU_NOP;
			dmem[i] <= fillWord(i);
		end
		progLen = 0;
		expAddr.delete();
		expData.delete();
	endtask

	task automatic reportMismatch(string signal, word_t expected, word_t actual);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, signal, expected, actual);
		errorCount++;
	endtask

	task automatic noteFailure(string message);
		$display("%s", message);
		errorCount++;
	endtask

	`include "test_programs.svh"

	// ----------------------------------------
	// Port checks on the falling edge
	// ----------------------------------------
	always @(negedge clock) begin
		if (reset) begin
			if (resetApplied) begin
				assert (fetchAddress == `CPU_PC_RESET)
					else reportMismatch("fetchAddress", `CPU_PC_RESET, fetchAddress);
				assert (!dataRequest.read && !dataRequest.write)
					else noteFailure("Data port strobe active while the core is in reset");
			end
		end else begin
			if (dataRequest.read) begin
				readsSeen++;
			end
			if (dataRequest.write) begin
				assert (expAddr.size() != 0)
					else noteFailure($sformatf("Unexpected store to %h at %0t",
						dataRequest.address, $time));
				if (expAddr.size() != 0) begin
					assert (dataRequest.address == expAddr[0])
						else reportMismatch("dataRequest.address", expAddr[0], dataRequest.address);
					assert (dataRequest.writeData == expData[0])
						else reportMismatch("dataRequest.writeData", expData[0],
							dataRequest.writeData);
					void'(expAddr.pop_front());
					void'(expData.pop_front());
				end
			end
		end
	end

	// Reset, load one program, then run to its last store or the budget
	task automatic runTest(string name, int id, bit usesLoad);
		int cycles;
		int budget;
		int errorsBefore;
		errorsBefore = errorCount;
		@(negedge clock);
		reset <= 1'b1;
		repeat (2) @(posedge clock); // Core idle by the second edge
		@(negedge clock);
		clearMemories();
		case (id)
			0:       loadAluChain();
			1:       loadImmediates();
			2:       loadLoadUse();
			3:       loadFlow();
			default: loadRandom();
		endcase
		readsSeen = 0;
		reset <= 1'b0;
		budget = progLen * 3 + 10;
		cycles = 0;
		while (expAddr.size() != 0 && cycles < budget) begin
			@(posedge clock);
			cycles++;
		end
		assert (expAddr.size() == 0)
			else noteFailure($sformatf("Test %s ended with %0d expected stores missing",
				name, expAddr.size()));
		assert (!usesLoad || readsSeen > 0)
			else noteFailure($sformatf("Test %s never showed a read strobe", name));
		if (errorCount == errorsBefore) begin
			testsPassed++;
			$display("Test %s passed after %0d cycles", name, cycles);
		end else begin
			testsFailed++;
			$display("Test %s failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	initial begin
		clock       = 1'b0;
		reset       = 1'b1;
		errorCount  = 0;
		testsPassed = 0;
		testsFailed = 0;
		readsSeen   = 0;
		clearMemories();
		runTest("aluChain", 0, 1'b0);
		runTest("immediates", 1, 1'b0);
		runTest("loadUse", 2, 1'b1);
		runTest("flow", 3, 1'b0);
		runTest("random", 4, 1'b1);
		$display("Tests passed: %0d, failed: %0d, errors: %0d",
			testsPassed, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog, three cycles per instruction plus reset margin
	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb.f
+incdir+verilog
+incdir+bench
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/fetchUnit.sv
verilog/registerFile.sv
verilog/decodeUnit.sv
verilog/executeUnit.sv
verilog/cpuCore.sv
bench/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build the core and testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f --top-module cpuTb \
	&& ./obj_dir/VcpuTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -sqx "RESULT: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
